/* design/config_pkg.sv */
package config_pkg;

  // width of a node id as it travels in a frame
  localparam int id_width_c = 6;

  // width of the payload each node stores
  localparam int data_width_c = 16;

  // id and data together, the part of a frame that a node captures
  localparam int payload_bits_c = id_width_c + data_width_c;

  // start bit, id, data and stop bit, one bit per clock
  localparam int frame_bits_c = 1 + payload_bits_c + 1;

  // bit positions inside a frame, counted from the start bit
  localparam int id_lsb_c = 1;
  localparam int data_lsb_c = id_lsb_c + id_width_c;
  localparam int stop_pos_c = frame_bits_c - 1;

  // line levels. The stop bit and the idle line share the same level
  localparam logic start_bit_c = 1'b0;
  localparam logic stop_bit_c = 1'b1;
  localparam logic line_idle_c = 1'b1;

  // counters track the frame position, so they must reach frame_bits_c
  localparam int count_width_c = $clog2(frame_bits_c + 1);
  localparam logic [count_width_c-1:0] first_index_c = count_width_c'(1);
  localparam logic [count_width_c-1:0] stop_index_c = count_width_c'(stop_pos_c);

  // every node accepts a frame carrying this id
  localparam logic [id_width_c-1:0] broadcast_id_c = id_width_c'(63);

  // chain length and the id of each node in chain order
  localparam int num_nodes_c = 3;
  localparam logic [id_width_c-1:0] node0_id_c = id_width_c'(1);
  localparam logic [id_width_c-1:0] node1_id_c = id_width_c'(2);
  localparam logic [id_width_c-1:0] node2_id_c = id_width_c'(3);

endpackage

/* design/config_setter.sv */
module config_setter (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                valid,
  output logic                                ready,
  input  logic [config_pkg::id_width_c-1:0]   id,
  input  logic [config_pkg::data_width_c-1:0] data,
  output logic                                cfg_bit
);

  // bits still waiting in the shift register after the one on the line
  logic [config_pkg::count_width_c-1:0] count_q;

  // everything after the start bit: id, data, then the stop bit on top
  logic [config_pkg::payload_bits_c:0] shift_q;

  // one host word is taken per handshake
  logic accept;

  // the counter is zero while idle and during the stop bit, so the next
  // word can be taken right as the current frame ends
  assign ready = (count_q == '0);
  assign accept = valid && ready;

  // control state and the line itself
  // the start bit goes out straight from the accepting edge, after that the
  // shift register feeds the line until the counter runs out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
      cfg_bit <= config_pkg::line_idle_c;
    end else if (accept) begin
      // stop_index_c bits remain once the start bit is out
      count_q <= config_pkg::stop_index_c;
      cfg_bit <= config_pkg::start_bit_c;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
      cfg_bit <= shift_q[0];
    end else begin
      // the line rests high between frames
      cfg_bit <= config_pkg::line_idle_c;
    end
  end

  // frame payload, least significant bit leaves first
  // the id sits in the low bits so it goes out before the data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= {config_pkg::stop_bit_c, data, id};
    end else if (count_q != '0) begin
      shift_q <= {config_pkg::line_idle_c, shift_q[config_pkg::payload_bits_c:1]};
    end
  end

  // a zero counter means idle or the stop bit, and both hold the line high
  a_idle_line_high: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (count_q == '0) |-> (cfg_bit == config_pkg::line_idle_c)
  );

  // once a word is taken the host is held off until the stop bit
  a_ready_low_in_frame: assert property (
    @(posedge clk_i) disable iff (reset_i)
    accept |=> !ready [* config_pkg::frame_bits_c - 1]
  );

endmodule

/* design/config_node.sv */
module config_node #(
  parameter logic [config_pkg::id_width_c-1:0] node_id_p = config_pkg::node0_id_c
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                cfg_in,
  output logic                                cfg_out,
  output logic [config_pkg::data_width_c-1:0] node_data
);

  // position of the bit currently on cfg_in, zero while waiting for a start
  logic [config_pkg::count_width_c-1:0] count_q;

  // id and data collected from the line, the newest bit enters at the top
  logic [config_pkg::payload_bits_c-1:0] shift_q;

  // fields of the captured frame
  logic [config_pkg::id_width_c-1:0]   rx_id;
  logic [config_pkg::data_width_c-1:0] rx_data;

  // decode of the current position
  logic idle;
  logic at_stop;
  logic id_hit;

  assign idle = (count_q == '0);
  assign at_stop = (count_q == config_pkg::stop_index_c);

  // after all payload bits have shifted in, the id ends up in the low bits
  // because it was sent first
  assign rx_id = shift_q[config_pkg::id_width_c-1:0];
  assign rx_data = shift_q[config_pkg::payload_bits_c-1:config_pkg::id_width_c];

  // a frame is for this node when it names it directly or names everyone
  assign id_hit = (rx_id == node_id_p) || (rx_id == config_pkg::broadcast_id_c);

  // relay to the next node
  // this runs on its own and does not care whether a frame is for us,
  // so the whole chain sees every frame one cycle later per hop
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_out <= config_pkg::line_idle_c;
    end else begin
      cfg_out <= cfg_in;
    end
  end

  // frame position counter
  // a low line while idle is taken as a start bit, and the counter then
  // walks through the id and data bits up to the stop bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (idle) begin
      if (cfg_in == config_pkg::start_bit_c) begin
        count_q <= config_pkg::first_index_c;
      end
    end else if (at_stop) begin
      // back to idle, so a start bit right after the stop is caught
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // payload capture
  // only the id and data bits are shifted, the start and stop bits never
  // enter the register
  always_ff @(posedge clk_i) begin
    if (!idle && !at_stop) begin
      shift_q <= {cfg_in, shift_q[config_pkg::payload_bits_c-1:1]};
    end
  end

  // the stored configuration word
  // it changes only at the end of a frame that carries a matching id,
  // frames for other nodes leave it alone
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      node_data <= '0;
    end else if (at_stop && id_hit) begin
      node_data <= rx_data;
    end
  end

  // the counter wraps to idle at the stop bit and can never run past a frame
  a_count_in_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    count_q <= config_pkg::count_width_c'(config_pkg::frame_bits_c)
  );

  // a frame started here takes exactly the frame length to come back to idle
  a_frame_length: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (idle && cfg_in == config_pkg::start_bit_c)
      |=> !idle [* config_pkg::frame_bits_c - 1] ##1 idle
  );

endmodule

/* design/config_chain_top.sv */
module config_chain_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                valid,
  output logic                                ready,
  input  logic [config_pkg::id_width_c-1:0]   id,
  input  logic [config_pkg::data_width_c-1:0] data,
  output logic [config_pkg::data_width_c-1:0] node0_data,
  output logic [config_pkg::data_width_c-1:0] node1_data,
  output logic [config_pkg::data_width_c-1:0] node2_data,
  output logic                                chain_bit
);

  // serial line from the setter into the first node
  logic cfg_bit;

  // hops between neighbouring nodes
  logic link0;
  logic link1;

  // host words become framed bits here
  config_setter setter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid   (valid),
    .ready   (ready),
    .id      (id),
    .data    (data),
    .cfg_bit (cfg_bit)
  );

  // first node sees the setter output directly
  config_node #(
    .node_id_p (config_pkg::node0_id_c)
  ) node0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_in    (cfg_bit),
    .cfg_out   (link0),
    .node_data (node0_data)
  );

  // second node, one cycle behind the first
  config_node #(
    .node_id_p (config_pkg::node1_id_c)
  ) node1 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_in    (link0),
    .cfg_out   (link1),
    .node_data (node1_data)
  );

  // last node, its relay output leaves the chain
  // chain_bit is therefore the setter line delayed by num_nodes_c cycles
  config_node #(
    .node_id_p (config_pkg::node2_id_c)
  ) node2 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_in    (link1),
    .cfg_out   (chain_bit),
    .node_data (node2_data)
  );

endmodule

/* tests/config_chain_ref.svh */
`ifndef CONFIG_CHAIN_REF_SVH
`define CONFIG_CHAIN_REF_SVH

// frame bit n for a word, n counted from the start bit
// the layout is start (0), id lsb first, data lsb first, stop (1)
function automatic logic frame_bit(input id_t fid, input data_t fdata, input int n);
  id_t   id_shift;
  data_t data_shift;
  if (n == 0) begin
    return 1'b0;
  end else if (n <= config_pkg::id_width_c) begin
    id_shift = fid >> (n - 1);
    return id_shift[0];
  end else if (n <= config_pkg::id_width_c + config_pkg::data_width_c) begin
    data_shift = fdata >> (n - 1 - config_pkg::id_width_c);
    return data_shift[0];
  end
  // stop bit and anything past the frame sit at the idle level
  return 1'b1;
endfunction

// id given to each position in the chain
function automatic id_t node_id_of(input int k);
  case (k)
    0:       return config_pkg::node0_id_c;
    1:       return config_pkg::node1_id_c;
    default: return config_pkg::node2_id_c;
  endcase
endfunction

// register of node k once a write has passed it
// a node takes the payload for its own id or the broadcast id, else keeps old
function automatic data_t expected_node_value(input int k, input id_t wid,
                                               input data_t wdata, input data_t old);
  if (wid == node_id_of(k) || wid == config_pkg::broadcast_id_c) begin
    return wdata;
  end
  return old;
endfunction

// compare one node data word
task automatic check_data(input data_t actual, input data_t expected, input string what);
  if (actual !== expected) begin
    stop_with_failure($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
  end
endtask

// compare one single-bit output
task automatic check_bit(input logic actual, input logic expected, input string what);
  if (actual !== expected) begin
    stop_with_failure($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
                                $time, what, actual, expected));
  end
endtask

`endif

/* tests/config_chain_tb.sv */
module config_chain_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [config_pkg::id_width_c-1:0]   id_t;
  typedef logic [config_pkg::data_width_c-1:0] data_t;

  localparam int unsigned seed_c = 32'h5694_aebe;
  localparam int ready_limit_c = 4 * config_pkg::frame_bits_c;
  localparam int idle_limit_c = 8 * config_pkg::frame_bits_c;
  localparam int random_words_c = 40;

  logic  clk_i = 1'b0;
  logic  reset_i;
  logic  valid;
  logic  ready;
  id_t   id;
  data_t data;
  data_t node0_data;
  data_t node1_data;
  data_t node2_data;
  logic  chain_bit;

  // posedge count, the accepting edge of a word is its index here
  int edge_no = 0;
  int last_accept = -1000;
  bit checking = 1'b0;

  // expected setter line per edge, edges not in the map carry the idle 1
  logic line_model [int];

  // exp_node is what the outputs show now, sched_node includes writes in flight
  data_t exp_node [config_pkg::num_nodes_c] = '{default: '0};
  data_t sched_node [config_pkg::num_nodes_c] = '{default: '0};

  // node updates waiting for their edge, kept in edge order
  int    upd_edge_q [$];
  int    upd_node_q [$];
  data_t upd_val_q [$];

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "config_chain_ref.svh"

  config_chain_top DUT (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid      (valid),
    .ready      (ready),
    .id         (id),
    .data       (data),
    .node0_data (node0_data),
    .node1_data (node1_data),
    .node2_data (node2_data),
    .chain_bit  (chain_bit)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic line_at(input int e);
    if (line_model.exists(e)) begin
      return line_model[e];
    end
    return 1'b1;
  endfunction

  function automatic data_t node_out(input int k);
    case (k)
      0:       return node0_data;
      1:       return node1_data;
      default: return node2_data;
    endcase
  endfunction

  // inputs were set on the falling edge, so they are settled here
  // frame bit n goes out after edge a+n and node k loads after edge a+24+k
  always @(posedge clk_i) begin
    edge_no = edge_no + 1;
    if (!reset_i && valid && ready) begin
      last_accept = edge_no;
      for (int n = 0; n < config_pkg::frame_bits_c; n++) begin
        line_model[edge_no + n] = frame_bit(id, data, n);
      end
      for (int k = 0; k < config_pkg::num_nodes_c; k++) begin
        sched_node[k] = expected_node_value(k, id, data, sched_node[k]);
        upd_edge_q.push_back(edge_no + config_pkg::frame_bits_c + k);
        upd_node_q.push_back(k);
        upd_val_q.push_back(sched_node[k]);
      end
    end
  end

  // compare every output once per cycle, midway between rising edges
  always @(negedge clk_i) begin : compare_outputs
    logic exp_ready;
    if (checking) begin
      while (upd_edge_q.size() > 0 && upd_edge_q[0] <= edge_no) begin
        exp_node[upd_node_q[0]] = upd_val_q[0];
        void'(upd_edge_q.pop_front());
        void'(upd_node_q.pop_front());
        void'(upd_val_q.pop_front());
      end
      // the host is held off from cycle 1 to cycle 23 of a frame
      exp_ready = !(edge_no >= last_accept &&
                    edge_no <= last_accept + config_pkg::frame_bits_c - 2);
      check_bit(ready, exp_ready, "ready");
      check_bit(chain_bit, line_at(edge_no - config_pkg::num_nodes_c), "chain_bit");
      for (int k = 0; k < config_pkg::num_nodes_c; k++) begin
        check_data(node_out(k), exp_node[k], $sformatf("node%0d_data", k));
      end
    end
  end

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_word(input id_t wid, input data_t wdata);
    int waited;
    waited = 0;
    valid = 1'b1;
    id = wid;
    data = wdata;
    while (!ready) begin
      @(negedge clk_i);
      waited++;
      if (waited > ready_limit_c) begin
        stop_with_failure("setter never raised ready for a pending word");
      end
    end
    @(negedge clk_i);
    valid = 1'b0;
  endtask

  // wait until all node updates landed and the last frame left the chain
  task automatic wait_idle();
    int waited;
    waited = 0;
    while (upd_edge_q.size() > 0 ||
           edge_no <= last_accept + config_pkg::frame_bits_c + config_pkg::num_nodes_c) begin
      @(negedge clk_i);
      waited++;
      if (waited > idle_limit_c) begin
        stop_with_failure("chain did not go idle after the last word");
      end
    end
  endtask

  // a node id, the broadcast id or an id nobody owns
  function automatic id_t random_id();
    int pick;
    pick = int'($urandom_range(0, 3));
    if (pick < 2) begin
      return node_id_of(int'($urandom_range(0, 2)));
    end else if (pick == 2) begin
      return config_pkg::broadcast_id_c;
    end else if ($urandom_range(0, 1) == 0) begin
      return '0;
    end
    return id_t'($urandom_range(4, 62));
  endfunction

  initial begin
    int gap;
    reset_i = 1'b1;
    valid = 1'b0;
    id = '0;
    data = '0;
    void'($urandom(seed_c));
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;

    // reset state of the handshake, the line and every node
    check_bit(ready, 1'b1, "ready after reset");
    check_bit(chain_bit, 1'b1, "chain_bit after reset");
    for (int k = 0; k < config_pkg::num_nodes_c; k++) begin
      check_data(node_out(k), '0, $sformatf("node%0d_data after reset", k));
    end
    checking = 1'b1;

    // one write per node, each should touch only its own register
    for (int k = 0; k < config_pkg::num_nodes_c; k++) begin
      send_word(node_id_of(k), data_t'($urandom));
      wait_idle();
    end

    // broadcast reaches all three nodes
    send_word(config_pkg::broadcast_id_c, data_t'($urandom));
    wait_idle();

    // ids nobody owns still travel the whole chain
    send_word(id_t'(0), data_t'($urandom));
    send_word(id_t'(40), data_t'($urandom));
    wait_idle();

    // mixed traffic, about half the words go back to back
    for (int w = 0; w < random_words_c; w++) begin
      gap = ($urandom_range(0, 1) == 0) ? 0 : int'($urandom_range(1, 4));
      for (int g = 0; g < gap; g++) begin
        @(negedge clk_i);
      end
      send_word(random_id(), data_t'($urandom));
    end
    wait_idle();

    for (int k = 0; k < config_pkg::num_nodes_c; k++) begin
      check_data(node_out(k), sched_node[k], $sformatf("final node%0d_data", k));
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* files.f */
+incdir+tests
design/config_pkg.sv
design/config_setter.sv
design/config_node.sv
design/config_chain_top.sv
tests/config_chain_tb.sv

/* Makefile */
# Verilator build and run of the configuration chain testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP ?= config_chain_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# build the model and run it, a failing run leaves a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
